// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := memPipeTb
RTL_TOP    := memPipe
FILELIST   := memPipe.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== memPipe.f ====
+incdir+source
source/memPipePkg.sv
source/memOpDecoder.sv
source/dataMemory.sv
source/memExecuteStage.sv
source/ioApbMaster.sv
source/memAccessStage.sv
source/memPipe.sv
sim/apbIoModel.sv
sim/memPipeTb.sv

// ==== sim/apbIoModel.sv ====
// ####################
// APB completer model with four word registers
// Adds 0 to 3 random wait states to each transfer
// ####################

`timescale 1ns/10ps

`include "memPipe_defs.svh"

module apbIoModel (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`MEM_ADDR_WIDTH-1:0] paddr,
    input  logic [`MEM_DATA_WIDTH-1:0] pwdata,
    output logic                       pready,
    output logic [`MEM_DATA_WIDTH-1:0] prdata
);

    logic [`MEM_DATA_WIDTH-1:0] regs [4];
    logic [1:0]                 waitLeft = 2'd0;
    logic                       readyReg = 1'b0;
    logic [`MEM_DATA_WIDTH-1:0] readData = '0;
    integer                     seed = 36;

    assign pready = readyReg;
    assign prdata = readData;

    always @(posedge clk) begin
        logic [1:0] draw;
        if (rst) begin
            readyReg <= 1'b0;
            waitLeft <= 2'd0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (psel && !penable) begin
            // Setup phase picks the wait states
            draw = 2'($random(seed));
            waitLeft <= draw;
            readyReg <= (draw == 2'd0);
            readData <= regs[paddr[3:2]];
        end else if (psel && penable && !readyReg) begin
            waitLeft <= waitLeft - 2'd1;
            readyReg <= (waitLeft == 2'd1);
        end else begin
            if (psel && penable && pwrite) begin
                regs[paddr[3:2]] <= pwdata;
            end
            readyReg <= 1'b0;
        end
    end

endmodule

// ==== sim/memPipeTb.sv ====
// ####################
// Testbench for the memory pipe with an APB register model on the IO side
// Drives ops on the falling edge, checks every writeback against a queue model
// ####################

`timescale 1ns/10ps

`include "memPipe_defs.svh"

module memPipeTb import memPipePkg::*; ();

    localparam int RESET_CYCLES  = 10;
    localparam int IDX_WIDTH     = $clog2(`MEM_DEPTH);
    // About 50 ops, each under 20 cycles with drains and wait states, doubled
    localparam int TIMEOUT_LIMIT = RESET_CYCLES + 50 * 20 * 2;

    typedef struct packed {
        logic                       timed;
        int                         due;
        logic [`PREG_TAG_WIDTH-1:0] tag;
        logic [`MEM_DATA_WIDTH-1:0] data;
    } expectedWb;

    typedef struct packed {
        logic                       write;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`MEM_DATA_WIDTH-1:0] data;
    } expectedApb;

    logic                       clk = 1'b0;
    logic                       rst;
    memIssueOp                  issue;
    logic                       stall;
    flushRange                  flush;
    logic                       pready;
    logic [`MEM_DATA_WIDTH-1:0] prdata;
    logic                       issueReady;
    memWriteback                wb;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`MEM_ADDR_WIDTH-1:0] paddr;
    logic [`MEM_DATA_WIDTH-1:0] pwdata;

    expectedWb                  expQ[$];
    expectedApb                 apbQ[$];
    logic [`MEM_DATA_WIDTH-1:0] refMem [`MEM_DEPTH];
    logic [`MEM_DATA_WIDTH-1:0] refIo [4];
    int                         cycleCount = 0;
    int                         errorCount = 0;
    int                         checkCount = 0;
    int                         testErrors = 0;
    logic                       rstLast = 1'b1;
    logic                       timedMode = 1'b1;
    integer                     seed = 36;

    always #5 clk = ~clk;

    memPipe dut (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .stall      (stall),
        .flush      (flush),
        .pready     (pready),
        .prdata     (prdata),
        .issueReady (issueReady),
        .wb         (wb),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata)
    );

    apbIoModel ioModel (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pready  (pready),
        .prdata  (prdata)
    );

    // Circular distance from head decides membership
    function automatic logic inFlushRange(input logic [4:0] ptr, input flushRange range);
        logic [4:0] fromHead;
        logic [4:0] span;
        fromHead = ptr - range.headPtr;
        span     = range.tailPtr - range.headPtr;
        return range.flushAll || (fromHead < span);
    endfunction

    function automatic flushRange makeRange(input logic all, input logic [4:0] head,
                                            input logic [4:0] tail);
        flushRange range;
        range.valid    = 1'b1;
        range.flushAll = all;
        range.headPtr  = head;
        range.tailPtr  = tail;
        return range;
    endfunction

    task automatic issueOp(input memOpCode code, input logic [31:0] base,
                           input logic [31:0] offset, input logic [31:0] data,
                           input logic [5:0] tag, input logic [4:0] ptr, input logic dropped);
        logic [31:0] addr;
        expectedWb   exp;
        expectedApb  xfer;
        addr = base + offset;
        @(negedge clk);
        issue.valid         = 1'b1;
        issue.opCode        = code;
        issue.base          = base;
        issue.offset        = offset;
        issue.storeData     = data;
        issue.dstTag        = tag;
        issue.activeListPtr = ptr;
        do @(posedge clk); while (!issueReady);
        exp.timed = timedMode;
        exp.due   = cycleCount + 2;
        exp.tag   = tag;
        exp.data  = addr;
        if (code == OP_STORE && addr >= `MEM_IO_BASE) begin
            if (!dropped) begin
                refIo[addr[3:2]] = data;
            end
        end else if (code == OP_STORE) begin
            refMem[addr[IDX_WIDTH+1:2]] = data;
        end else if (code == OP_LOAD && addr >= `MEM_IO_BASE) begin
            exp.data = refIo[addr[3:2]];
        end else if (code == OP_LOAD) begin
            exp.data = refMem[addr[IDX_WIDTH+1:2]];
        end
        if (code != OP_STORE && !dropped) begin
            expQ.push_back(exp);
        end
        // IO loads and stores each own one APB transfer
        if (code != OP_ADDR && addr >= `MEM_IO_BASE && !dropped) begin
            xfer.write = (code == OP_STORE);
            xfer.addr  = addr;
            xfer.data  = data;
            apbQ.push_back(xfer);
        end
    endtask

    task automatic idleCycles(input int n);
        @(negedge clk);
        issue.valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drainPipe();
        idleCycles(3);
        while (expQ.size() != 0 || !issueReady) begin
            @(negedge clk);
        end
    endtask

    task automatic finishTest(input string name);
        drainPipe();
        $display("Test %s finished with %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    // Op reaches the access stage, then is stalled and hit by a flush range
    task automatic flushHeldOp(input memOpCode code, input logic [31:0] addr,
                               input logic [31:0] data, input logic [5:0] tag,
                               input logic [4:0] ptr, input flushRange range);
        drainPipe();
        issueOp(code, addr, 32'h0, data, tag, ptr, inFlushRange(ptr, range));
        idleCycles(1);
        stall = 1'b1;
        flush = range;
        @(negedge clk);
        flush.valid = 1'b0;
        repeat (2) @(negedge clk);
        stall = 1'b0;
    endtask

    always @(posedge clk) begin
        expectedWb  head;
        expectedApb xfer;
        cycleCount <= cycleCount + 1;
        rstLast    <= rst;
        if (cycleCount >= TIMEOUT_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end else if (cycleCount > 0) begin
            if (rst || rstLast) begin
                checkCount++;
                assert (!wb.valid && !psel && !penable && !issueReady) else begin
                    errorCount++;
                    $display("At %0t an output was active in or right after reset", $time);
                end
            end
            if (stall) begin
                checkCount++;
                assert (!wb.valid && !issueReady) else begin
                    errorCount++;
                    $display("At %0t wb.valid or issueReady was high under stall", $time);
                end
            end
            if (psel) begin
                checkCount++;
                assert (!issueReady) else begin
                    errorCount++;
                    $display("At %0t issueReady was high during an APB transfer", $time);
                end
            end
            // Setup phase of each APB transfer
            if (psel && !penable) begin
                checkCount++;
                assert (apbQ.size() > 0) else begin
                    errorCount++;
                    $display("At %0t an APB transfer to %h was not expected", $time, paddr);
                end
                if (apbQ.size() > 0) begin
                    xfer = apbQ.pop_front();
                    assert (paddr == xfer.addr) else begin
                        errorCount++;
                        $display("MISMATCH at %0t: paddr got %h expected %h",
                                 $time, paddr, xfer.addr);
                    end
                    assert (pwrite == xfer.write) else begin
                        errorCount++;
                        $display("MISMATCH at %0t: pwrite got %b expected %b",
                                 $time, pwrite, xfer.write);
                    end
                    assert (!xfer.write || pwdata == xfer.data) else begin
                        errorCount++;
                        $display("MISMATCH at %0t: pwdata got %h expected %h",
                                 $time, pwdata, xfer.data);
                    end
                end
            end
            if (wb.valid) begin
                checkCount++;
                assert (expQ.size() > 0) else begin
                    errorCount++;
                    $display("At %0t a writeback for tag %0d was not expected", $time, wb.dstTag);
                end
                if (expQ.size() > 0) begin
                    head = expQ.pop_front();
                    assert (wb.dstTag == head.tag) else begin
                        errorCount++;
                        $display("MISMATCH at %0t: wb.dstTag got %0d expected %0d",
                                 $time, wb.dstTag, head.tag);
                    end
                    assert (wb.data == head.data) else begin
                        errorCount++;
                        $display("MISMATCH at %0t: wb.data got %h expected %h",
                                 $time, wb.data, head.data);
                    end
                    assert (!head.timed || cycleCount == head.due) else begin
                        errorCount++;
                        $display("At %0t the writeback for tag %0d was not 2 cycles after issue",
                                 $time, head.tag);
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] addrs [8];
        logic [31:0] offset;
        rst   = 1'b1;
        issue = '0;
        stall = 1'b0;
        flush = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        finishTest("reset");

        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed) & 32'h3fc;
            offset   = $random(seed) & 32'hff;
            issueOp(OP_STORE, addrs[i] - offset, offset, $random(seed), 6'(i), 5'(i), 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            issueOp(OP_LOAD, addrs[i], 32'h0, 32'h0, 6'(8 + i), 5'(8 + i), 1'b0);
        end
        finishTest("memoryStoreLoad");

        for (int i = 0; i < 6; i++) begin
            issueOp(OP_ADDR, $random(seed), $random(seed), 32'h0, 6'(16 + i), 5'(16 + i), 1'b0);
            issueOp(OP_STORE, 32'h100, 4 * i, $random(seed), 6'd63, 5'(16 + i), 1'b0);
        end
        finishTest("addressOnly");

        // IO latency varies, so no fixed cycle check from here on
        timedMode = 1'b0;
        for (int i = 0; i < 4; i++) begin
            issueOp(OP_STORE, `MEM_IO_BASE, 4 * i, $random(seed), 6'(24 + i), 5'(24 + i), 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            issueOp(OP_LOAD, `MEM_IO_BASE + 4 * i, 32'h0, 32'h0, 6'(28 + i), 5'(28 + i), 1'b0);
        end
        finishTest("ioRegisters");

        flushHeldOp(OP_LOAD, addrs[0], 32'h0, 6'd40, 5'd6, makeRange(1'b0, 5'd4, 5'd9));
        flushHeldOp(OP_LOAD, addrs[1], 32'h0, 6'd41, 5'd12, makeRange(1'b0, 5'd4, 5'd9));
        flushHeldOp(OP_ADDR, 32'h48, 32'h0, 6'd42, 5'd12, makeRange(1'b1, 5'd0, 5'd0));
        flushHeldOp(OP_ADDR, 32'h4c, 32'h0, 6'd43, 5'd1, makeRange(1'b0, 5'd30, 5'd3));
        flushHeldOp(OP_ADDR, 32'h50, 32'h0, 6'd44, 5'd20, makeRange(1'b0, 5'd30, 5'd3));
        flushHeldOp(OP_STORE, `MEM_IO_BASE + 8, 32'hdead_beef, 6'd45, 5'd7,
                    makeRange(1'b1, 5'd0, 5'd0));
        issueOp(OP_LOAD, `MEM_IO_BASE, 32'h8, 32'h0, 6'd46, 5'd8, 1'b0);
        finishTest("selectiveFlush");

        issueOp(OP_LOAD, addrs[2], 32'h0, 32'h0, 6'd50, 5'd0, 1'b0);
        issueOp(OP_ADDR, 32'h1234, 32'h10, 32'h0, 6'd51, 5'd1, 1'b0);
        issueOp(OP_LOAD, addrs[3], 32'h0, 32'h0, 6'd52, 5'd2, 1'b0);
        @(negedge clk);
        issue.valid = 1'b0;
        stall       = 1'b1;
        fork
            begin
                repeat (4) @(negedge clk);
                stall = 1'b0;
            end
            issueOp(OP_ADDR, 32'h2000, 32'h24, 32'h0, 6'd53, 5'd3, 1'b0);
        join
        finishTest("stall");

        if (expQ.size() != 0 || apbQ.size() != 0) begin
            errorCount++;
            $display("Expected writebacks or APB transfers were still outstanding at the end");
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== source/dataMemory.sv ====
// ####################
// Single-port word RAM for the memory pipe
// Read data only updates on readEnable, so it holds under stall
// ####################

`timescale 1ns/10ps

`include "memPipe_defs.svh"

module dataMemory #(
    parameter int DEPTH = `MEM_DEPTH,
    parameter int WIDTH = `MEM_DATA_WIDTH
) (
    input  logic                     clk,
    input  logic                     readEnable,
    input  logic                     writeEnable,
    input  logic [$clog2(DEPTH)-1:0] wordAddr,
    input  logic [WIDTH-1:0]         writeData,
    output logic [WIDTH-1:0]         readData
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[wordAddr] <= writeData;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (readEnable) begin
            readData <= mem[wordAddr];
        end
    end

endmodule

// ==== source/ioApbMaster.sv ====
// ####################
// APB requester for IO loads and stores
// Start while idle, done pulses one cycle after pready is seen
// ####################

`timescale 1ns/10ps

`include "memPipe_defs.svh"

module ioApbMaster import memPipePkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       write,
    input  logic [`MEM_ADDR_WIDTH-1:0] addr,
    input  logic [`MEM_DATA_WIDTH-1:0] wdata,
    input  logic                       pready,
    input  logic [`MEM_DATA_WIDTH-1:0] prdata,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [`MEM_ADDR_WIDTH-1:0] paddr,
    output logic [`MEM_DATA_WIDTH-1:0] pwdata,
    output logic                       done,
    output logic [`MEM_DATA_WIDTH-1:0] rdata
);

    apbState state;
    logic    launch;
    logic    finish;

    // No relaunch in the done cycle, the op is still in the access stage
    assign launch = (state == APB_IDLE) && start && !done;
    assign finish = (state == APB_ACCESS) && pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= APB_IDLE;
            done  <= 1'b0;
        end else begin
            done <= finish;
            case (state)
                APB_IDLE:   if (launch) state <= APB_SETUP;
                APB_SETUP:  state <= APB_ACCESS;
                APB_ACCESS: if (pready) state <= APB_IDLE;
                default:    state <= APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            pwrite <= write;
            paddr  <= addr;
            pwdata <= wdata;
        end
        if (finish) begin
            rdata <= prdata;
        end
    end

    assign psel    = (state != APB_IDLE);
    assign penable = (state == APB_ACCESS);

endmodule

// ==== source/memAccessStage.sv ====
// ####################
// Access step: result select, selective flush and writeback
// Also hands IO ops to the APB requester and reports ioBusy
// ####################

`timescale 1ns/10ps

`include "memPipe_defs.svh"

module memAccessStage import memPipePkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hold,
    input  memExecReg                  execReg,
    input  logic [`MEM_DATA_WIDTH-1:0] memData,
    input  flushRange                  flush,
    input  logic                       ioDone,
    input  logic [`MEM_DATA_WIDTH-1:0] ioData,
    output memExecReg                  ioOp,
    output logic                       ioStart,
    output logic                       ioBusy,
    output memWriteback                wb
);

    memAccessReg accessReg;
    logic        flushed;
    logic        inRange;
    logic        ioFinished;
    logic        ioPending;

    // Circular range test on the active-list pointer
    always_comb begin
        if (flush.headPtr <= flush.tailPtr) begin
            inRange = (accessReg.op.activeListPtr >= flush.headPtr) &&
                      (accessReg.op.activeListPtr < flush.tailPtr);
        end else begin
            inRange = (accessReg.op.activeListPtr >= flush.headPtr) ||
                      (accessReg.op.activeListPtr < flush.tailPtr);
        end
    end

    assign flushed = flush.valid && accessReg.op.valid && (flush.flushAll || inRange);

    always_ff @(posedge clk) begin
        if (rst) begin
            accessReg.op.valid <= 1'b0;
        end else if (!hold) begin
            accessReg.op      <= execReg;
            accessReg.memData <= memData;
        end else if (flushed) begin
            accessReg.op.valid <= 1'b0;
        end
    end

    // Remembers a finished transfer while a stall keeps the op here
    always_ff @(posedge clk) begin
        if (rst || !hold) begin
            ioFinished <= 1'b0;
        end else if (ioDone) begin
            ioFinished <= 1'b1;
        end
    end

    assign ioPending = accessReg.op.valid && !flushed && !ioFinished &&
                       (accessReg.op.mapType == MMT_IO) &&
                       (accessReg.op.isLoad || accessReg.op.isStore);
    assign ioStart = ioPending;
    assign ioBusy  = ioPending && !ioDone;
    assign ioOp    = accessReg.op;

    always_comb begin
        wb.valid  = accessReg.op.valid && !flushed && !hold &&
                    (accessReg.op.isLoad || accessReg.op.isAddr);
        wb.dstTag = accessReg.op.dstTag;
        if (accessReg.op.isAddr) begin
            wb.data = accessReg.op.addr;
        end else if (accessReg.op.mapType == MMT_IO) begin
            wb.data = ioData;
        end else begin
            wb.data = accessReg.memData;
        end
    end

endmodule

// ==== source/memExecuteStage.sv ====
// ####################
// Execute step: latches the decoded op and accesses the data RAM
// RAM access and register load share the same edge
// ####################

`timescale 1ns/10ps

`include "memPipe_defs.svh"

module memExecuteStage import memPipePkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hold,
    input  memExecReg                  decoded,
    output memExecReg                  execReg,
    output logic [`MEM_DATA_WIDTH-1:0] memData
);

    localparam int IDX_WIDTH = $clog2(`MEM_DEPTH);

    logic                 memAccess;
    logic [IDX_WIDTH-1:0] wordIndex;

    assign memAccess = decoded.valid && !hold && (decoded.mapType == MMT_MEMORY);
    // Byte address to word index
    assign wordIndex = decoded.addr[IDX_WIDTH+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            execReg.valid <= 1'b0;
        end else if (!hold) begin
            execReg <= decoded;
        end
    end

    dataMemory ram (
        .clk         (clk),
        .readEnable  (memAccess && decoded.isLoad),
        .writeEnable (memAccess && decoded.isStore),
        .wordAddr    (wordIndex),
        .writeData   (decoded.storeData),
        .readData    (memData)
    );

endmodule

// ==== source/memOpDecoder.sv ====
// ####################
// Address generation and op classification
// Purely combinational, sits in front of the execute register
// ####################

`timescale 1ns/10ps

`include "memPipe_defs.svh"

module memOpDecoder import memPipePkg::*; (
    input  memIssueOp op,
    output memExecReg decoded
);

    logic [`MEM_ADDR_WIDTH-1:0] effAddr;

    assign effAddr = op.base + op.offset;

    always_comb begin
        decoded.valid         = op.valid;
        decoded.addr          = effAddr;
        decoded.storeData     = op.storeData;
        decoded.dstTag        = op.dstTag;
        decoded.activeListPtr = op.activeListPtr;
        decoded.mapType       = (effAddr >= `MEM_IO_BASE) ? MMT_IO : MMT_MEMORY;

        decoded.isLoad  = 1'b0;
        decoded.isStore = 1'b0;
        decoded.isAddr  = 1'b0;
        case (op.opCode)
            OP_LOAD:  decoded.isLoad  = 1'b1;
            OP_STORE: decoded.isStore = 1'b1;
            OP_ADDR:  decoded.isAddr  = 1'b1;
            // Unused encoding acts as a bubble
            default:  decoded.valid   = 1'b0;
        endcase
    end

endmodule

// ==== source/memPipe.sv ====
// ####################
// Memory pipe top: decode, execute and access steps plus the IO unit
// One issue lane, writeback doubles as the bypass
// ####################

`timescale 1ns/10ps

`include "memPipe_defs.svh"

module memPipe import memPipePkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  memIssueOp                  issue,
    input  logic                       stall,
    input  flushRange                  flush,
    input  logic                       pready,
    input  logic [`MEM_DATA_WIDTH-1:0] prdata,
    output logic                       issueReady,
    output memWriteback                wb,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [`MEM_ADDR_WIDTH-1:0] paddr,
    output logic [`MEM_DATA_WIDTH-1:0] pwdata
);

    memExecReg                  decoded;
    memExecReg                  execReg;
    memExecReg                  ioOp;
    logic [`MEM_DATA_WIDTH-1:0] memData;
    logic [`MEM_DATA_WIDTH-1:0] ioData;
    logic                       ioStart;
    logic                       ioBusy;
    logic                       ioDone;
    logic                       running;
    logic                       hold;

    // Keeps the pipe closed through reset
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign hold       = stall || ioBusy || !running;
    assign issueReady = !hold;

    memOpDecoder decoder (
        .op      (issue),
        .decoded (decoded)
    );

    memExecuteStage exStage (
        .clk     (clk),
        .rst     (rst),
        .hold    (hold),
        .decoded (decoded),
        .execReg (execReg),
        .memData (memData)
    );

    memAccessStage maStage (
        .clk     (clk),
        .rst     (rst),
        .hold    (hold),
        .execReg (execReg),
        .memData (memData),
        .flush   (flush),
        .ioDone  (ioDone),
        .ioData  (ioData),
        .ioOp    (ioOp),
        .ioStart (ioStart),
        .ioBusy  (ioBusy),
        .wb      (wb)
    );

    ioApbMaster ioUnit (
        .clk     (clk),
        .rst     (rst),
        .start   (ioStart),
        .write   (ioOp.isStore),
        .addr    (ioOp.addr),
        .wdata   (ioOp.storeData),
        .pready  (pready),
        .prdata  (prdata),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .done    (ioDone),
        .rdata   (ioData)
    );

endmodule

// ==== source/memPipePkg.sv ====
// ####################
// Shared enums and stage structs of the memory pipe
// Imported by every pipe module that uses them
// ####################

`include "memPipe_defs.svh"

package memPipePkg;

    typedef enum logic [1:0] {
        OP_LOAD,
        OP_STORE,
        OP_ADDR
    } memOpCode;

    typedef enum logic {
        MMT_MEMORY,
        MMT_IO
    } memMapType;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apbState;

    typedef struct packed {
        logic                              valid;
        memOpCode                          opCode;
        logic [`MEM_DATA_WIDTH-1:0]        base;
        logic [`MEM_DATA_WIDTH-1:0]        offset;
        logic [`MEM_DATA_WIDTH-1:0]        storeData;
        logic [`PREG_TAG_WIDTH-1:0]        dstTag;
        logic [`ACTIVE_LIST_PTR_WIDTH-1:0] activeListPtr;
    } memIssueOp;

    typedef struct packed {
        logic                              valid;
        logic                              isLoad;
        logic                              isStore;
        logic                              isAddr;
        memMapType                         mapType;
        logic [`MEM_ADDR_WIDTH-1:0]        addr;
        logic [`MEM_DATA_WIDTH-1:0]        storeData;
        logic [`PREG_TAG_WIDTH-1:0]        dstTag;
        logic [`ACTIVE_LIST_PTR_WIDTH-1:0] activeListPtr;
    } memExecReg;

    typedef struct packed {
        memExecReg                  op;
        logic [`MEM_DATA_WIDTH-1:0] memData;
    } memAccessReg;

    // Head inclusive, tail exclusive
    typedef struct packed {
        logic                              valid;
        logic                              flushAll;
        logic [`ACTIVE_LIST_PTR_WIDTH-1:0] headPtr;
        logic [`ACTIVE_LIST_PTR_WIDTH-1:0] tailPtr;
    } flushRange;

    typedef struct packed {
        logic                       valid;
        logic [`PREG_TAG_WIDTH-1:0] dstTag;
        logic [`MEM_DATA_WIDTH-1:0] data;
    } memWriteback;

endpackage

// ==== source/memPipe_defs.svh ====
// ####################
// Width, depth and address map constants for the memory pipe
// Include this wherever a width or the IO base is needed
// ####################

`ifndef MEM_PIPE_DEFS_SVH
`define MEM_PIPE_DEFS_SVH

// Data path
`define MEM_DATA_WIDTH 32
`define MEM_ADDR_WIDTH 32

// Word count of the data RAM
`define MEM_DEPTH 256

// Addresses from here upwards are served over APB
`define MEM_IO_BASE 32'h8000_0000

// Back-end bookkeeping
`define ACTIVE_LIST_PTR_WIDTH 5
`define PREG_TAG_WIDTH 6

`endif
